// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tl_io_tb -o Vtl_io_tb

out=$(./obj_dir/Vtl_io_tb)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
else
  exit 1
fi

// ==== src/tl_io_config.svh ====
`ifndef TL_IO_CONFIG_SVH
`define TL_IO_CONFIG_SVH

// Channel field widths
`define TL_ADDR_W 16
`define TL_DATA_W 32
`define TL_SRC_W 4

// Lane count and where the lane select sits in the address
`define TL_NUM_LANES 4
`define TL_LANE_W 2
`define TL_REGION_LSB 12

// Words held by each register-file device
`define TL_REGION_WORDS 16

`endif

// ==== src/tl_io_pkg.sv ====
`default_nettype none

package tl_io_pkg;

  `include "tl_io_config.svh"

  // A channel opcodes, TileLink encoding
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    ArithmeticData = 3'h2,
    LogicalData    = 3'h3,
    Get            = 3'h4,
    Intent         = 3'h5,
    AcquireBlock   = 3'h6,
    AcquirePerm    = 3'h7
  } tl_a_op_e;

  // D channel opcodes used by this subsystem
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1,
    Grant         = 3'h4,
    GrantData     = 3'h5
  } tl_d_op_e;

  typedef struct packed {
    tl_a_op_e                  opcode;
    logic [2:0]                param;
    logic [`TL_SRC_W-1:0]      source;
    logic [`TL_ADDR_W-1:0]     address;
    logic [`TL_DATA_W/8-1:0]   mask;
    logic [`TL_DATA_W-1:0]     data;
  } tl_a_t;

  typedef struct packed {
    tl_d_op_e                  opcode;
    logic [`TL_SRC_W-1:0]      source;
    logic                      denied;
    logic                      corrupt;
    logic [`TL_DATA_W-1:0]     data;
  } tl_d_t;

endpackage

`default_nettype wire

// ==== src/tl_io_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tl_io_config.svh"

module tl_io_ram import tl_io_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  tl_link_if.device link
);

  localparam int idx_w = $clog2(`TL_REGION_WORDS);
  localparam int off_w = $clog2(`TL_DATA_W / 8);

  logic [`TL_DATA_W-1:0] mem_q [`TL_REGION_WORDS];
  logic [idx_w-1:0]      idx;
  logic [`TL_DATA_W-1:0] wmask;
  logic                  a_xfer;
  logic                  wr_en;
  logic                  rsp_valid_q;
  tl_d_t                 rsp_q;

  assign idx    = link.a.address[off_w +: idx_w];
  assign a_xfer = link.a_valid && link.a_ready;
  assign wr_en  = a_xfer && (link.a.opcode inside {PutFullData, PutPartialData});

  // Full writes ignore the mask
  for (genvar b = 0; b < `TL_DATA_W / 8; b++) begin : g_byte
    assign wmask[8*b +: 8] = {8{link.a.opcode == PutFullData || link.a.mask[b]}};
  end

  // No new request while a response is still held
  assign link.a_ready = !rsp_valid_q;
  assign link.d_valid = rsp_valid_q;
  assign link.d       = rsp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      for (int w = 0; w < `TL_REGION_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else begin
      if (a_xfer) begin
        rsp_valid_q <= 1'b1;
      end else if (link.d_ready) begin
        rsp_valid_q <= 1'b0;
      end
      if (wr_en) begin
        mem_q[idx] <= (mem_q[idx] & ~wmask) | (link.a.data & wmask);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_xfer) begin
      rsp_q.opcode  <= (link.a.opcode == Get) ? AccessAckData : AccessAck;
      rsp_q.source  <= link.a.source;
      rsp_q.denied  <= 1'b0;
      rsp_q.corrupt <= 1'b0;
      rsp_q.data    <= (link.a.opcode == Get) ? mem_q[idx] : '0;
    end
  end

endmodule

`default_nettype wire

// ==== src/tl_io_terminator.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tl_io_config.svh"

module tl_io_terminator import tl_io_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  tl_link_if.device host,
  tl_link_if.host   device
);

  typedef enum logic [1:0] {
    st_idle,
    st_active,
    st_deny
  } state_e;

  state_e state_q, state_d;
  logic   req_sent_q, req_sent_d;
  logic   permitted;

  // Captured request
  tl_a_op_e                op_q;
  logic [`TL_SRC_W-1:0]    src_q;
  logic [`TL_ADDR_W-1:0]   addr_q;
  logic [`TL_DATA_W/8-1:0] mask_q;
  logic [`TL_DATA_W-1:0]   data_q;

  // Only plain reads and writes reach the device
  always_comb begin
    case (host.a.opcode)
      Get, PutFullData, PutPartialData: permitted = 1'b1;
      default:                          permitted = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Request and response sequencing
  ////////////////////////////////////////

  always_comb begin
    host.a_ready   = 1'b0;
    host.d_valid   = 1'b0;
    host.d         = '0;
    device.a_valid = 1'b0;
    device.a       = '0;
    device.d_ready = 1'b0;
    state_d        = state_q;
    req_sent_d     = req_sent_q;

    unique case (state_q)
      st_idle: begin
        host.a_ready = 1'b1;
        if (host.a_valid) begin
          req_sent_d = 1'b0;
          state_d    = permitted ? st_active : st_deny;
        end
      end

      st_active: begin
        // Issue once, then wait for the device answer
        device.a_valid        = !req_sent_q;
        device.a.opcode       = op_q;
        device.a.param        = 3'b000;
        device.a.source       = src_q;
        device.a.address      = addr_q;
        device.a.mask         = mask_q;
        device.a.data         = data_q;
        if (device.a_valid && device.a_ready) begin
          req_sent_d = 1'b1;
        end

        host.d_valid   = device.d_valid;
        host.d         = device.d;
        host.d.source  = src_q;
        device.d_ready = host.d_ready;
        if (device.d_valid && host.d_ready) begin
          state_d = st_idle;
        end
      end

      st_deny: begin
        host.d_valid   = 1'b1;
        host.d.opcode  = (op_q inside {AcquireBlock, AcquirePerm}) ? Grant : AccessAck;
        host.d.source  = src_q;
        host.d.denied  = 1'b1;
        host.d.corrupt = 1'b0;
        host.d.data    = '0;
        if (host.d_ready) begin
          state_d = st_idle;
        end
      end

      default: state_d = st_idle;
    endcase
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= st_idle;
      req_sent_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      req_sent_q <= req_sent_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == st_idle && host.a_valid) begin
      op_q   <= host.a.opcode;
      src_q  <= host.a.source;
      addr_q <= host.a.address;
      mask_q <= host.a.mask;
      data_q <= host.a.data;
    end
  end

endmodule

`default_nettype wire

// ==== src/tl_io_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tl_io_config.svh"

module tl_io_top import tl_io_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    host_a_valid_i,
  input  logic [2:0]              host_a_opcode_i,
  input  logic [2:0]              host_a_param_i,
  input  logic [`TL_SRC_W-1:0]    host_a_source_i,
  input  logic [`TL_ADDR_W-1:0]   host_a_address_i,
  input  logic [`TL_DATA_W/8-1:0] host_a_mask_i,
  input  logic [`TL_DATA_W-1:0]   host_a_data_i,
  output logic                    host_a_ready_o,

  output logic                    host_d_valid_o,
  output logic [2:0]              host_d_opcode_o,
  output logic [`TL_SRC_W-1:0]    host_d_source_o,
  output logic                    host_d_denied_o,
  output logic                    host_d_corrupt_o,
  output logic [`TL_DATA_W-1:0]   host_d_data_o,
  input  logic                    host_d_ready_i
);

  tl_a_t host_a;
  tl_d_t host_d;

  // Host lanes and device links, one of each per region
  tl_link_if lane_a   [`TL_NUM_LANES] ();
  tl_link_if dev_link [`TL_NUM_LANES] ();

  assign host_a.opcode  = tl_a_op_e'(host_a_opcode_i);
  assign host_a.param   = host_a_param_i;
  assign host_a.source  = host_a_source_i;
  assign host_a.address = host_a_address_i;
  assign host_a.mask    = host_a_mask_i;
  assign host_a.data    = host_a_data_i;

  tl_region_demux u_demux (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .host_a_valid_i (host_a_valid_i),
    .host_a_i       (host_a),
    .host_a_ready_o (host_a_ready_o),
    .lane_a         (lane_a)
  );

  for (genvar i = 0; i < `TL_NUM_LANES; i++) begin : g_lane
    tl_io_terminator u_term (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .host   (lane_a[i]),
      .device (dev_link[i])
    );

    tl_io_ram u_ram (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .link   (dev_link[i])
    );
  end

  tl_resp_arbiter u_arb (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lane_d         (lane_a),
    .host_d_valid_o (host_d_valid_o),
    .host_d_o       (host_d),
    .host_d_ready_i (host_d_ready_i)
  );

  assign host_d_opcode_o  = host_d.opcode;
  assign host_d_source_o  = host_d.source;
  assign host_d_denied_o  = host_d.denied;
  assign host_d_corrupt_o = host_d.corrupt;
  assign host_d_data_o    = host_d.data;

endmodule

`default_nettype wire

// ==== src/tl_link_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Single-beat A and D channels with valid/ready handshakes
interface tl_link_if import tl_io_pkg::*; ();

  logic  a_valid;
  logic  a_ready;
  tl_a_t a;

  logic  d_valid;
  logic  d_ready;
  tl_d_t d;

  modport host (
    output a_valid, a, d_ready,
    input  a_ready, d_valid, d
  );

  modport device (
    input  a_valid, a, d_ready,
    output a_ready, d_valid, d
  );

endinterface

`default_nettype wire

// ==== src/tl_region_demux.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tl_io_config.svh"

module tl_region_demux import tl_io_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    host_a_valid_i,
  input  tl_a_t   host_a_i,
  output logic    host_a_ready_o,
  tl_link_if.host lane_a [`TL_NUM_LANES]
);

  logic [`TL_LANE_W-1:0]    region;
  logic [`TL_NUM_LANES-1:0] sel;
  logic [`TL_NUM_LANES-1:0] lane_ready;
  logic [`TL_NUM_LANES-1:0] lane_d_xfer;
  logic [`TL_NUM_LANES-1:0] busy_q;
  logic                     accept_en_q;

  // Bits above the region field are ignored, so those addresses alias
  assign region = host_a_i.address[`TL_REGION_LSB +: `TL_LANE_W];
  assign sel    = `TL_NUM_LANES'(1) << region;

  for (genvar i = 0; i < `TL_NUM_LANES; i++) begin : g_lane
    assign lane_a[i].a_valid = accept_en_q && host_a_valid_i && sel[i] && !busy_q[i];
    assign lane_a[i].a       = host_a_i;
    assign lane_ready[i]     = lane_a[i].a_ready;
    assign lane_d_xfer[i]    = lane_a[i].d_valid && lane_a[i].d_ready;
  end

  assign host_a_ready_o = accept_en_q && |(sel & ~busy_q & lane_ready);

  // A lane stays busy from its A transfer until its answer leaves on D
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= '0;
      accept_en_q <= 1'b0;
    end else begin
      accept_en_q <= 1'b1;
      busy_q      <= (busy_q & ~lane_d_xfer) |
                     (sel & {`TL_NUM_LANES{host_a_valid_i && host_a_ready_o}});
    end
  end

endmodule

`default_nettype wire

// ==== src/tl_resp_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tl_io_config.svh"

module tl_resp_arbiter import tl_io_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  tl_link_if.host lane_d [`TL_NUM_LANES],
  output logic    host_d_valid_o,
  output tl_d_t   host_d_o,
  input  logic    host_d_ready_i
);

  localparam int lane_w = $clog2(`TL_NUM_LANES);

  logic [`TL_NUM_LANES-1:0] req;
  logic [`TL_NUM_LANES-1:0] gnt;
  tl_d_t                    lane_rsp [`TL_NUM_LANES];
  logic [lane_w-1:0]        ptr_q;
  logic [lane_w-1:0]        gnt_idx;
  logic                     gnt_any;
  logic                     take;
  logic                     out_valid_q;
  tl_d_t                    out_q;

  // Output register is free when empty or emptying this cycle
  assign take = !out_valid_q || host_d_ready_i;

  for (genvar i = 0; i < `TL_NUM_LANES; i++) begin : g_lane
    assign req[i]           = lane_d[i].d_valid;
    assign lane_rsp[i]      = lane_d[i].d;
    assign lane_d[i].d_ready = take && gnt[i];
  end

  // Round robin, search starts at the pointer
  always_comb begin
    logic [lane_w-1:0] cand;
    gnt     = '0;
    gnt_idx = ptr_q;
    gnt_any = 1'b0;
    for (int k = 0; k < `TL_NUM_LANES; k++) begin
      cand = ptr_q + lane_w'(k);
      if (!gnt_any && req[cand]) begin
        gnt_any = 1'b1;
        gnt_idx = cand;
      end
    end
    gnt[gnt_idx] = gnt_any;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
      ptr_q       <= '0;
    end else if (take) begin
      out_valid_q <= gnt_any;
      if (gnt_any) begin
        ptr_q <= gnt_idx + lane_w'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take && gnt_any) begin
      out_q <= lane_rsp[gnt_idx];
    end
  end

  assign host_d_valid_o = out_valid_q;
  assign host_d_o       = out_q;

endmodule

`default_nettype wire

// ==== testbench/tl_io_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tl_io_config.svh"

module tl_io_chk (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  a_valid_i,
  input logic                  a_ready_i,
  input logic [`TL_SRC_W-1:0]  a_source_i,
  input logic                  d_valid_i,
  input logic                  d_ready_i,
  input logic [2:0]            d_opcode_i,
  input logic [`TL_SRC_W-1:0]  d_source_i,
  input logic                  d_denied_i,
  input logic                  d_corrupt_i,
  input logic [`TL_DATA_W-1:0] d_data_i
);

  logic [(1<<`TL_SRC_W)-1:0] pend_q;
  logic [`TL_DATA_W+`TL_SRC_W+4:0] d_payload;

  assign d_payload = {d_opcode_i, d_source_i, d_denied_i, d_corrupt_i, d_data_i};

  // Sources with a request accepted and no answer yet
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= '0;
    end else begin
      if (d_valid_i && d_ready_i) begin
        pend_q[d_source_i] <= 1'b0;
      end
      if (a_valid_i && a_ready_i) begin
        pend_q[a_source_i] <= 1'b1;
      end
    end
  end

  d_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_i && !d_ready_i |=> d_valid_i && $stable(d_payload))
    else $error("D channel changed while stalled");

  d_owner_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_i && d_ready_i |-> pend_q[d_source_i])
    else $error("D response for a source with nothing outstanding");

  reset_idle_a: assert property (@(posedge clk_i)
    !rst_ni |-> !a_ready_i && !d_valid_i)
    else $error("Handshake active during reset");

endmodule

bind tl_io_top tl_io_chk u_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .a_valid_i   (host_a_valid_i),
  .a_ready_i   (host_a_ready_o),
  .a_source_i  (host_a_source_i),
  .d_valid_i   (host_d_valid_o),
  .d_ready_i   (host_d_ready_i),
  .d_opcode_i  (host_d_opcode_o),
  .d_source_i  (host_d_source_o),
  .d_denied_i  (host_d_denied_o),
  .d_corrupt_i (host_d_corrupt_o),
  .d_data_i    (host_d_data_o)
);

`default_nettype wire

// ==== testbench/tl_io_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tl_io_config.svh"

module tl_io_monitor import tl_io_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      a_valid_i,
  input  logic                      a_ready_i,
  input  logic [2:0]                a_opcode_i,
  input  logic [`TL_SRC_W-1:0]      a_source_i,
  input  logic [`TL_ADDR_W-1:0]     a_address_i,
  input  logic [`TL_DATA_W/8-1:0]   a_mask_i,
  input  logic [`TL_DATA_W-1:0]     a_data_i,
  input  logic                      d_valid_i,
  input  logic                      d_ready_i,
  input  logic [2:0]                d_opcode_i,
  input  logic [`TL_SRC_W-1:0]      d_source_i,
  input  logic                      d_denied_i,
  input  logic                      d_corrupt_i,
  input  logic [`TL_DATA_W-1:0]     d_data_i,
  output logic [(1<<`TL_SRC_W)-1:0] pending_o,
  output int                        err_count_o,
  output int                        rsp_count_o
);

  localparam int num_src = 1 << `TL_SRC_W;

  // Shadow of every device word, and the answer owed to each source
  logic [`TL_DATA_W-1:0] shadow [`TL_NUM_LANES][`TL_REGION_WORDS];
  tl_d_op_e              exp_op [num_src];
  logic                  exp_denied [num_src];
  logic [`TL_DATA_W-1:0] exp_data [num_src];
  logic                  chk_data [num_src];

  initial begin
    err_count_o = 0;
    rsp_count_o = 0;
    pending_o   = '0;
    for (int l = 0; l < `TL_NUM_LANES; l++) begin
      for (int w = 0; w < `TL_REGION_WORDS; w++) begin
        shadow[l][w] = '0;
      end
    end
  end

  function automatic bit is_permitted(tl_a_op_e op);
    return op inside {Get, PutFullData, PutPartialData};
  endfunction

  function automatic tl_d_op_e expected_opcode(tl_a_op_e op);
    if (op == Get) return AccessAckData;
    if (op inside {AcquireBlock, AcquirePerm}) return Grant;
    return AccessAck;
  endfunction

  task automatic compare_field(input string what, input logic [`TL_SRC_W-1:0] src,
                               input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t: source %0d %s is %0h, expected %0h", $time, src, what, got, exp);
      err_count_o++;
    end
  endtask

  always @(posedge clk_i) begin
    logic [`TL_SRC_W-1:0]  s;
    logic [`TL_LANE_W-1:0] lane;
    logic [3:0]            word;
    tl_a_op_e              op;
    logic [num_src-1:0]    pend_next;
    int                    rsp_next;
    pend_next = pending_o;
    rsp_next  = rsp_count_o;
    if (!rst_ni) begin
      pend_next = '0;
    end else begin
      if (d_valid_i && d_ready_i) begin
        s = d_source_i;
        if (!pending_o[s]) begin
          $display("Unexpected response at %0t: source %0d has no request outstanding",
                   $time, s);
          err_count_o++;
        end else begin
          compare_field("opcode", s, 32'(d_opcode_i), 32'(exp_op[s]));
          compare_field("denied", s, 32'(d_denied_i), 32'(exp_denied[s]));
          compare_field("corrupt", s, 32'(d_corrupt_i), 32'd0);
          if (chk_data[s]) begin
            compare_field("data", s, d_data_i, exp_data[s]);
          end
        end
        pend_next[s] = 1'b0;
        rsp_next++;
      end
      if (a_valid_i && a_ready_i) begin
        s    = a_source_i;
        op   = tl_a_op_e'(a_opcode_i);
        lane = a_address_i[`TL_REGION_LSB +: `TL_LANE_W];
        word = a_address_i[5:2];
        exp_op[s]     = expected_opcode(op);
        exp_denied[s] = !is_permitted(op);
        chk_data[s]   = is_permitted(op);
        exp_data[s]   = (op == Get) ? shadow[lane][word] : '0;
        // Only permitted writes touch memory
        if (op inside {PutFullData, PutPartialData}) begin
          for (int b = 0; b < `TL_DATA_W / 8; b++) begin
            if (op == PutFullData || a_mask_i[b]) begin
              shadow[lane][word][8*b +: 8] = a_data_i[8*b +: 8];
            end
          end
        end
        pend_next[s] = 1'b1;
      end
    end
    pending_o   <= pend_next;
    rsp_count_o <= rsp_next;
  end

endmodule

`default_nettype wire

// ==== testbench/tl_io_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tl_io_config.svh"

module tl_io_tb import tl_io_pkg::*; ();

  localparam int num_req     = 400;
  localparam int cycle_limit = num_req * 12 + 100;

  logic                    clk;
  logic                    rst_n;
  logic                    a_valid;
  logic [2:0]              a_opcode;
  logic [2:0]              a_param;
  logic [`TL_SRC_W-1:0]    a_source;
  logic [`TL_ADDR_W-1:0]   a_address;
  logic [`TL_DATA_W/8-1:0] a_mask;
  logic [`TL_DATA_W-1:0]   a_data;
  logic                    a_ready;
  logic                    d_valid;
  logic [2:0]              d_opcode;
  logic [`TL_SRC_W-1:0]    d_source;
  logic                    d_denied;
  logic                    d_corrupt;
  logic [`TL_DATA_W-1:0]   d_data;
  logic                    d_ready;

  logic [(1<<`TL_SRC_W)-1:0] pending;
  logic [`TL_SRC_W-1:0]      last_src;
  int                        err_count;
  int                        rsp_count;
  int                        cycles = 0;
  integer                    seed;

  tl_io_top uut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .host_a_valid_i   (a_valid),
    .host_a_opcode_i  (a_opcode),
    .host_a_param_i   (a_param),
    .host_a_source_i  (a_source),
    .host_a_address_i (a_address),
    .host_a_mask_i    (a_mask),
    .host_a_data_i    (a_data),
    .host_a_ready_o   (a_ready),
    .host_d_valid_o   (d_valid),
    .host_d_opcode_o  (d_opcode),
    .host_d_source_o  (d_source),
    .host_d_denied_o  (d_denied),
    .host_d_corrupt_o (d_corrupt),
    .host_d_data_o    (d_data),
    .host_d_ready_i   (d_ready)
  );

  tl_io_monitor u_monitor (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .a_valid_i   (a_valid),
    .a_ready_i   (a_ready),
    .a_opcode_i  (a_opcode),
    .a_source_i  (a_source),
    .a_address_i (a_address),
    .a_mask_i    (a_mask),
    .a_data_i    (a_data),
    .d_valid_i   (d_valid),
    .d_ready_i   (d_ready),
    .d_opcode_i  (d_opcode),
    .d_source_i  (d_source),
    .d_denied_i  (d_denied),
    .d_corrupt_i (d_corrupt),
    .d_data_i    (d_data),
    .pending_o   (pending),
    .err_count_o (err_count),
    .rsp_count_o (rsp_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, only %0d of %0d responses seen",
               cycles, rsp_count, num_req);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Host D back-pressure, ready low about one cycle in four
  task automatic next_cycle();
    @(posedge clk);
    d_ready <= ($unsigned($random(seed)) % 4) != 0;
  endtask

  task automatic send_request();
    int                   pick;
    tl_a_op_e             op;
    logic [`TL_SRC_W-1:0] src;
    pick = $unsigned($random(seed)) % 100;
    if (pick < 70) begin
      case ($unsigned($random(seed)) % 3)
        0:       op = Get;
        1:       op = PutFullData;
        default: op = PutPartialData;
      endcase
    end else begin
      case ($unsigned($random(seed)) % 5)
        0:       op = ArithmeticData;
        1:       op = LogicalData;
        2:       op = Intent;
        3:       op = AcquireBlock;
        default: op = AcquirePerm;
      endcase
    end
    // Skip sources still waiting for an answer
    src = `TL_SRC_W'($random(seed));
    while (pending[src] || src == last_src) begin
      src = src + 1'b1;
    end
    a_valid   <= 1'b1;
    a_opcode  <= op;
    a_param   <= 3'($random(seed));
    a_source  <= src;
    a_address <= `TL_ADDR_W'($random(seed));
    a_mask    <= 4'($random(seed));
    a_data    <= $random(seed);
  endtask

  initial begin
    logic accepted;
    seed      = 70461;
    rst_n     = 1'b0;
    a_valid   = 1'b0;
    a_opcode  = '0;
    a_param   = '0;
    a_source  = '0;
    a_address = '0;
    a_mask    = '0;
    a_data    = '0;
    d_ready   = 1'b0;
    last_src  = '0;
    accepted  = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    for (int n = 0; n < num_req; n++) begin
      send_request();
      // Ready is sampled mid-cycle, ahead of the edge that transfers
      do begin
        @(negedge clk);
        accepted = a_ready;
        next_cycle();
      end while (!accepted);
      last_src = a_source;
    end
    a_valid <= 1'b0;

    while (rsp_count < num_req) begin
      next_cycle();
    end
    repeat (5) next_cycle();

    $display("Summary: %0d errors, %0d requests, %0d responses",
             err_count, num_req, rsp_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+src
src/tl_io_pkg.sv
src/tl_link_if.sv
src/tl_region_demux.sv
src/tl_io_terminator.sv
src/tl_io_ram.sv
src/tl_resp_arbiter.sv
src/tl_io_top.sv
testbench/tl_io_chk.sv
testbench/tl_io_monitor.sv
testbench/tl_io_tb.sv
